//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f src.f --top-module tb_top -Mdir obj_dir -o Vtb_top

run: compile
	./obj_dir/Vtb_top +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int FRAME_W   = 8;
  localparam int FRAME_H   = 6;
  localparam int HW        = cam_pkg::HCOUNT_W;
  localparam int VW        = cam_pkg::VCOUNT_W;
  // camera model timing in clk_65mhz cycles
  localparam int BYTE_CYC  = 8;
  localparam int LINE_GAP  = 8;
  localparam int VS_LEN    = 8;
  localparam int N_FRAMES  = 8;
  localparam int FRAME_CYC = FRAME_H * (FRAME_W * 2 * BYTE_CYC + LINE_GAP) + 2 * VS_LEN;
  localparam int CYCLE_LIMIT = 2 * N_FRAMES * FRAME_CYC;
  // stalled far side, slowest ack and a long release
  localparam int STALL_DELAY = 8;
  localparam int ACK_HOLD    = 32;

  logic          clk_65mhz;
  logic          sys_rst;
  logic [7:0]    cam_data;
  logic          cam_pclk;
  logic          cam_vsync;
  logic          cam_href;
  logic          cam_xclk;
  logic [1:0]    thresh_sel;
  logic [3:0]    thresh_lo;
  logic [3:0]    thresh_hi;
  logic          com_req;
  logic          com_ack;
  logic [HW-1:0] com_x;
  logic [VW-1:0] com_y;
  logic          com_empty;

  // expected results, oldest frame first
  int exp_x_q[$];
  int exp_y_q[$];
  bit exp_e_q[$];
  // queue head, seen by the bound assertions
  logic [HW-1:0] exp_cur_x;
  logic [VW-1:0] exp_cur_y;
  logic          exp_cur_empty;

  // picture = background plus up to two rectangles
  logic [15:0] bg_color;
  int          rect_n;
  int          rect_x0[2];
  int          rect_y0[2];
  int          rect_x1[2];
  int          rect_y1[2];
  logic [15:0] rect_color[2];

  int seed = 97;
  bit prompt_ack;
  bit stall_ack;
  int handshakes;
  int err_cnt;
  int assert_fails;
  int errs_seen;
  int tests_ok;
  int tests_bad;
  int cycles;

  blob_tracker_top #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) DUT (
    .clk_65mhz  (clk_65mhz),
    .sys_rst    (sys_rst),
    .cam_data   (cam_data),
    .cam_pclk   (cam_pclk),
    .cam_vsync  (cam_vsync),
    .cam_href   (cam_href),
    .cam_xclk   (cam_xclk),
    .thresh_sel (thresh_sel),
    .thresh_lo  (thresh_lo),
    .thresh_hi  (thresh_hi),
    .com_req    (com_req),
    .com_ack    (com_ack),
    .com_x      (com_x),
    .com_y      (com_y),
    .com_empty  (com_empty)
  );

  bind blob_tracker_top tracker_asserts u_asserts (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .com_req   (com_req),
    .com_ack   (com_ack),
    .com_x     (com_x),
    .com_y     (com_y),
    .com_empty (com_empty),
    .cam_xclk  (cam_xclk)
  );

  // 4 ns period
  initial begin
    clk_65mhz = 1'b0;
    forever begin
      #2 clk_65mhz = ~clk_65mhz;
    end
  end

  always @(posedge clk_65mhz) begin
    if (exp_x_q.size() > 0) begin
      exp_cur_x     <= HW'(exp_x_q[0]);
      exp_cur_y     <= VW'(exp_y_q[0]);
      exp_cur_empty <= exp_e_q[0];
    end
  end

  function automatic logic [15:0] pixel_at(int x, int y);
    logic [15:0] w;
    int          i;
    w = bg_color;
    // later rectangles paint over earlier ones
    for (i = 0; i < rect_n; i++) begin
      if (x >= rect_x0[i] && x <= rect_x1[i] && y >= rect_y0[i] && y <= rect_y1[i]) begin
        w = rect_color[i];
      end
    end
    return w;
  endfunction

  // rgb565 bit positions, top four bits of each field
  function automatic bit in_window(logic [1:0] sel, logic [3:0] lo, logic [3:0] hi,
                                   logic [15:0] w);
    logic [3:0] c;
    case (sel)
      com_pkg::CHAN_RED:   c = w[15:12];
      com_pkg::CHAN_GREEN: c = w[10:7];
      com_pkg::CHAN_BLUE:  c = w[4:1];
      default:             return 1'b0;
    endcase
    return (c >= lo) && (c <= hi);
  endfunction

  task automatic set_picture(logic [15:0] bg);
    bg_color = bg;
    rect_n   = 0;
  endtask

  task automatic add_rect(int x0, int y0, int x1, int y1, logic [15:0] color);
    rect_x0[rect_n]    = x0;
    rect_y0[rect_n]    = y0;
    rect_x1[rect_n]    = x1;
    rect_y1[rect_n]    = y1;
    rect_color[rect_n] = color;
    rect_n++;
  endtask

  // floor centroid of the masked pixels, empty when none
  task automatic push_expected(logic [1:0] sel, logic [3:0] lo, logic [3:0] hi);
    int x;
    int y;
    int sx;
    int sy;
    int n;
    sx = 0;
    sy = 0;
    n  = 0;
    for (y = 0; y < FRAME_H; y++) begin
      for (x = 0; x < FRAME_W; x++) begin
        if (in_window(sel, lo, hi, pixel_at(x, y))) begin
          sx += x;
          sy += y;
          n++;
        end
      end
    end
    exp_x_q.push_back((n == 0) ? 0 : sx / n);
    exp_y_q.push_back((n == 0) ? 0 : sy / n);
    exp_e_q.push_back(n == 0);
  endtask

  // pclk low then high, data steady the whole byte
  task automatic send_byte(logic [7:0] b);
    cam_pclk <= 1'b0;
    cam_data <= b;
    repeat (BYTE_CYC / 2) @(posedge clk_65mhz);
    cam_pclk <= 1'b1;
    repeat (BYTE_CYC / 2) @(posedge clk_65mhz);
  endtask

  // lone vsync pulse, also closes a frame with no lines
  task automatic send_vsync();
    cam_vsync <= 1'b1;
    repeat (VS_LEN) @(posedge clk_65mhz);
    cam_vsync <= 1'b0;
    repeat (VS_LEN) @(posedge clk_65mhz);
  endtask

  task automatic send_frame(logic [1:0] sel, logic [3:0] lo, logic [3:0] hi);
    logic [15:0] w;
    int          x;
    int          y;
    thresh_sel <= sel;
    thresh_lo  <= lo;
    thresh_hi  <= hi;
    push_expected(sel, lo, hi);
    for (y = 0; y < FRAME_H; y++) begin
      cam_href <= 1'b1;
      for (x = 0; x < FRAME_W; x++) begin
        w = pixel_at(x, y);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
      end
      cam_href <= 1'b0;
      repeat (LINE_GAP) @(posedge clk_65mhz);
    end
    // vsync rise closes the frame
    send_vsync();
  endtask

  task automatic check_result();
    if (exp_x_q.size() == 0) begin
      $display("result offered at %0t ns with no frame pending", $time);
      err_cnt++;
    end else begin
      if (int'(com_x) != exp_x_q[0]) begin
        $display("[ERROR] %0t ns com_x: got %0d, expected %0d", $time, com_x, exp_x_q[0]);
        err_cnt++;
      end
      if (int'(com_y) != exp_y_q[0]) begin
        $display("[ERROR] %0t ns com_y: got %0d, expected %0d", $time, com_y, exp_y_q[0]);
        err_cnt++;
      end
      if (com_empty != exp_e_q[0]) begin
        $display("[ERROR] %0t ns com_empty: got %0b, expected %0b", $time, com_empty,
                 exp_e_q[0]);
        err_cnt++;
      end
      void'(exp_x_q.pop_front());
      void'(exp_y_q.pop_front());
      void'(exp_e_q.pop_front());
    end
  endtask

  task automatic wait_results(int target);
    while (handshakes < target) @(posedge clk_65mhz);
  endtask

  task automatic finish_test(string name);
    int errs;
    errs = err_cnt + assert_fails;
    if (errs == errs_seen) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d problem(s)", name, errs - errs_seen);
    end
    errs_seen = errs;
  endtask

  // far side of the four-phase handshake
  initial begin
    int delay;
    com_ack <= 1'b0;
    forever begin
      @(posedge clk_65mhz);
      if (com_req && !com_ack) begin
        check_result();
        if (stall_ack) begin
          delay = STALL_DELAY;
        end else begin
          delay = prompt_ack ? 1 : 1 + int'($unsigned($random(seed)) % 8);
        end
        repeat (delay) @(posedge clk_65mhz);
        com_ack <= 1'b1;
        @(posedge clk_65mhz);
        while (com_req) @(posedge clk_65mhz);
        // stalled far side keeps ack up a while longer
        if (stall_ack) begin
          repeat (ACK_HOLD) @(posedge clk_65mhz);
        end
        com_ack <= 1'b0;
        handshakes++;
      end
    end
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_65mhz);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d results received", cycles, handshakes);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    sys_rst    <= 1'b1;
    cam_data   <= 8'h00;
    cam_pclk   <= 1'b0;
    cam_vsync  <= 1'b0;
    cam_href   <= 1'b0;
    thresh_sel <= com_pkg::CHAN_RED;
    thresh_lo  <= 4'd0;
    thresh_hi  <= 4'd15;
    prompt_ack = 1'b0;
    stall_ack  = 1'b0;
    repeat (10) @(posedge clk_65mhz);
    sys_rst <= 1'b0;

    // gray background, every channel at 4
    set_picture(16'h4208);
    add_rect(1, 1, 4, 3, 16'hF800);
    send_frame(com_pkg::CHAN_RED, 4'd12, 4'd15);
    wait_results(1);
    finish_test("test 1 red rectangle");

    add_rect(5, 2, 7, 5, 16'h001F);
    send_frame(com_pkg::CHAN_BLUE, 4'd12, 4'd15);
    wait_results(2);
    finish_test("test 2 blue select");

    // window misses 0, 4 and 15
    send_frame(com_pkg::CHAN_RED, 4'd6, 4'd10);
    wait_results(3);
    finish_test("test 3 nothing masked");

    // slow random ack stresses the handshake checks
    set_picture(16'h4208);
    add_rect(0, 0, 2, 4, 16'h07E0);
    send_frame(com_pkg::CHAN_GREEN, 4'd13, 4'd15);
    wait_results(4);
    // stalled far side so empty frames land during req and then during ack
    stall_ack = 1'b1;
    send_frame(com_pkg::CHAN_GREEN, 4'd13, 4'd15);
    while (!com_req) @(posedge clk_65mhz);
    send_vsync();
    while (!(com_ack && !com_req)) @(posedge clk_65mhz);
    send_vsync();
    wait_results(5);
    stall_ack = 1'b0;
    finish_test("test 4 handshake");

    prompt_ack = 1'b1;
    set_picture(16'h4208);
    add_rect(6, 4, 7, 5, 16'hF800);
    send_frame(com_pkg::CHAN_RED, 4'd12, 4'd15);
    set_picture(16'h4208);
    add_rect(0, 3, 3, 3, 16'h001F);
    send_frame(com_pkg::CHAN_BLUE, 4'd12, 4'd15);
    // full window, whole frame counts
    set_picture(16'h4208);
    send_frame(com_pkg::CHAN_GREEN, 4'd0, 4'd15);
    wait_results(8);
    finish_test("test 5 back-to-back frames");

    sys_rst <= 1'b1;
    repeat (10) @(posedge clk_65mhz);
    sys_rst <= 1'b0;
    @(posedge clk_65mhz);
    if (com_req !== 1'b0) begin
      $display("[ERROR] %0t ns com_req: got %0b, expected 0", $time, com_req);
      err_cnt++;
    end
    repeat (16) @(posedge clk_65mhz);
    if (exp_x_q.size() != 0) begin
      $display("%0d frame(s) never produced a result", exp_x_q.size());
      err_cnt++;
    end
    finish_test("test 6 reset state and xclk");

    $display("tests passed %0d, failed %0d, handshakes %0d, errors %0d", tests_ok,
             tests_bad, handshakes, err_cnt + assert_fails);
    if (tests_bad == 0 && err_cnt + assert_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/tracker_asserts.sv
`timescale 1ns/1ps

module tracker_asserts (
  input logic                         clk_65mhz,
  input logic                         sys_rst,
  input logic                         com_req,
  input logic                         com_ack,
  input logic [cam_pkg::HCOUNT_W-1:0] com_x,
  input logic [cam_pkg::VCOUNT_W-1:0] com_y,
  input logic                         com_empty,
  input logic                         cam_xclk
);

  // no request while reset is applied
  a_reset_idle: assert property (@(posedge clk_65mhz) sys_rst |=> !com_req)
    else begin
      $error("com_req high during reset");
      tb_top.assert_fails++;
    end

  // sensor clock starts low
  a_xclk_reset: assert property (@(posedge clk_65mhz) $fell(sys_rst) |-> !cam_xclk)
    else begin
      $error("cam_xclk not low after reset");
      tb_top.assert_fails++;
    end

  // clk/4, each level lasts two cycles
  a_xclk_hold: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    $changed(cam_xclk) |=> $stable(cam_xclk))
    else begin
      $error("cam_xclk level shorter than two cycles");
      tb_top.assert_fails++;
    end

  a_xclk_toggle: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    !$past(sys_rst) && $stable(cam_xclk) |=> $changed(cam_xclk))
    else begin
      $error("cam_xclk level longer than two cycles");
      tb_top.assert_fails++;
    end

  // result frozen for the whole request phase
  a_req_stable: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    com_req && $past(com_req) |-> $stable(com_x) && $stable(com_y) && $stable(com_empty))
    else begin
      $error("result changed while com_req was high");
      tb_top.assert_fails++;
    end

  a_req_fall: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    $fell(com_req) |-> $past(com_ack))
    else begin
      $error("com_req dropped before com_ack was seen");
      tb_top.assert_fails++;
    end

  // new request only once ack is released
  a_req_rise: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    $rose(com_req) |-> !com_ack && !$past(com_ack))
    else begin
      $error("com_req rose while com_ack was high");
      tb_top.assert_fails++;
    end

  // offered centroid against the oldest pending frame
  a_result: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    $rose(com_req) |-> (com_x == tb_top.exp_cur_x) && (com_y == tb_top.exp_cur_y)
                       && (com_empty == tb_top.exp_cur_empty))
    else begin
      $error("offered centroid differs from the expected one");
      tb_top.assert_fails++;
    end

endmodule

//--- rtl/blob_tracker_top.sv
`timescale 1ns/1ps

module blob_tracker_top #(
  parameter int FRAME_W = cam_pkg::FRAME_W_DEF,
  parameter int FRAME_H = cam_pkg::FRAME_H_DEF
) (
  input  logic                         clk_65mhz,
  input  logic                         sys_rst,
  // camera bus
  input  logic [7:0]                   cam_data,
  input  logic                         cam_pclk,
  input  logic                         cam_vsync,
  input  logic                         cam_href,
  output logic                         cam_xclk,
  // threshold setup
  input  logic [1:0]                   thresh_sel,
  input  logic [3:0]                   thresh_lo,
  input  logic [3:0]                   thresh_hi,
  // centroid handshake
  output logic                         com_req,
  input  logic                         com_ack,
  output logic [cam_pkg::HCOUNT_W-1:0] com_x,
  output logic [cam_pkg::VCOUNT_W-1:0] com_y,
  output logic                         com_empty
);

  pix_stream_if pix ();
  com_sums_if   sums ();

  // divider to report
  logic [cam_pkg::HCOUNT_W-1:0] x_com;
  logic [cam_pkg::VCOUNT_W-1:0] y_com;
  logic                         empty;
  logic                         done;

  cam_capture #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) u_capture (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .cam_data  (cam_data),
    .cam_pclk  (cam_pclk),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .cam_xclk  (cam_xclk),
    .pix       (pix.source)
  );

  mask_accumulator u_accum (
    .clk_65mhz  (clk_65mhz),
    .sys_rst    (sys_rst),
    .thresh_sel (thresh_sel),
    .thresh_lo  (thresh_lo),
    .thresh_hi  (thresh_hi),
    .pix        (pix.sink),
    .sums       (sums.source)
  );

  com_divider u_divider (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .sums      (sums.sink),
    .x_com     (x_com),
    .y_com     (y_com),
    .empty     (empty),
    .done      (done)
  );

  com_report u_report (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .x_com     (x_com),
    .y_com     (y_com),
    .empty     (empty),
    .done      (done),
    .com_req   (com_req),
    .com_ack   (com_ack),
    .com_x     (com_x),
    .com_y     (com_y),
    .com_empty (com_empty)
  );

endmodule

//--- rtl/cam_capture.sv
`timescale 1ns/1ps

module cam_capture #(
  parameter int FRAME_W = cam_pkg::FRAME_W_DEF,
  parameter int FRAME_H = cam_pkg::FRAME_H_DEF
) (
  input  logic         clk_65mhz,
  input  logic         sys_rst,
  input  logic [7:0]   cam_data,
  input  logic         cam_pclk,
  input  logic         cam_vsync,
  input  logic         cam_href,
  output logic         cam_xclk,
  pix_stream_if.source pix
);

  localparam int HW = cam_pkg::HCOUNT_W;
  localparam int VW = cam_pkg::VCOUNT_W;

  // two-flop synchronizers
  logic [7:0] data_s1, data_s2;
  logic       pclk_s1, pclk_s2;
  logic       vsync_s1, vsync_s2;
  logic       href_s1, href_s2;

  // edge register stage
  logic       pclk_last, vsync_last, href_last;
  logic       pclk_rise, vsync_rise, href_fall;
  logic       href_r;
  logic [7:0] data_r;

  // pairing and coordinates
  logic          low_next;
  logic [HW-1:0] col;
  logic [VW-1:0] row;
  logic          col_ok, row_ok;

  // xclk divider
  logic xclk_div;

  // data bus needs no reset, it only matters with a pclk edge
  always_ff @(posedge clk_65mhz) begin
    data_s1 <= cam_data;
    data_s2 <= data_s1;
    data_r  <= data_s2;
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pclk_s1    <= 1'b0;
      pclk_s2    <= 1'b0;
      vsync_s1   <= 1'b0;
      vsync_s2   <= 1'b0;
      href_s1    <= 1'b0;
      href_s2    <= 1'b0;
      pclk_last  <= 1'b0;
      vsync_last <= 1'b0;
      href_last  <= 1'b0;
      pclk_rise  <= 1'b0;
      vsync_rise <= 1'b0;
      href_fall  <= 1'b0;
      href_r     <= 1'b0;
    end else begin
      pclk_s1    <= cam_pclk;
      pclk_s2    <= pclk_s1;
      vsync_s1   <= cam_vsync;
      vsync_s2   <= vsync_s1;
      href_s1    <= cam_href;
      href_s2    <= href_s1;
      pclk_last  <= pclk_s2;
      vsync_last <= vsync_s2;
      href_last  <= href_s2;
      // registered edges, third cycle after the port
      pclk_rise  <= pclk_s2 & ~pclk_last;
      vsync_rise <= vsync_s2 & ~vsync_last;
      href_fall  <= href_last & ~href_s2;
      href_r     <= href_s2;
    end
  end

  // stop counting past the frame edge
  assign col_ok = int'(col) < FRAME_W;
  assign row_ok = int'(row) < FRAME_H;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pix.pix_valid <= 1'b0;
      pix.frame_end <= 1'b0;
      low_next      <= 1'b0;
      col           <= '0;
      row           <= '0;
    end else begin
      pix.pix_valid <= 1'b0;
      pix.frame_end <= vsync_rise;
      if (vsync_rise) begin
        // new frame starts at the origin
        col      <= '0;
        row      <= '0;
        low_next <= 1'b0;
      end else if (href_fall) begin
        col      <= '0;
        low_next <= 1'b0;
        if (row_ok) begin
          row <= row + VW'(1);
        end
      end else if (pclk_rise && href_r) begin
        low_next <= ~low_next;
        if (low_next && col_ok && row_ok) begin
          pix.pix_valid <= 1'b1;
          col           <= col + HW'(1);
        end
      end
    end
  end

  // payload: bytes land straight in the union
  always_ff @(posedge clk_65mhz) begin
    if (pclk_rise && href_r && !vsync_rise && !href_fall) begin
      if (!low_next) begin
        pix.pixel.raw.hi <= data_r;
      end else begin
        pix.pixel.raw.lo <= data_r;
        pix.hcount       <= col;
        pix.vcount       <= row;
      end
    end
  end

  // clk/4 for the sensor, low out of reset
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      xclk_div <= 1'b0;
      cam_xclk <= 1'b0;
    end else begin
      xclk_div <= ~xclk_div;
      if (xclk_div) begin
        cam_xclk <= ~cam_xclk;
      end
    end
  end

endmodule

//--- rtl/cam_pkg.sv
package cam_pkg;

  // default sensor window, qvga
  localparam int FRAME_W_DEF = 320;
  localparam int FRAME_H_DEF = 240;

  // coordinate counter widths
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // one camera word, seen either as rgb565 or as the two bytes on the bus
  typedef union packed {
    struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
    } rgb;
    // hi byte arrives first on the bus
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } raw;
  } pixel_u;

endpackage

//--- rtl/com_divider.sv
`timescale 1ns/1ps

module com_divider (
  input  logic                         clk_65mhz,
  input  logic                         sys_rst,
  com_sums_if.sink                     sums,
  output logic [cam_pkg::HCOUNT_W-1:0] x_com,
  output logic [cam_pkg::VCOUNT_W-1:0] y_com,
  output logic                         empty,
  output logic                         done
);

  localparam int SW = com_pkg::SUM_W;
  localparam int HW = cam_pkg::HCOUNT_W;
  localparam int VW = cam_pkg::VCOUNT_W;
  localparam int CW = $clog2(SW + 1);

  logic [CW-1:0]   bit_cnt;
  logic            running;
  logic            load;
  logic [SW-1:0]   den;
  logic [SW-1:0]   rem_x, rem_y;
  // dividend shifts out the top while quotient bits enter below
  logic [SW-1:0]   quo_x, quo_y;
  logic [2*SW-1:0] step_x, step_y;

  // one restoring step, returns {remainder, quotient}
  function automatic logic [2*SW-1:0] div_step(
    input logic [SW-1:0] rem,
    input logic [SW-1:0] quo,
    input logic [SW-1:0] dvs
  );
    logic [SW:0] trial;
    logic [SW:0] diff;
    trial = {rem, quo[SW-1]};
    diff  = trial - {1'b0, dvs};
    // borrow means the trial was smaller, keep it
    if (diff[SW]) begin
      return {trial[SW-1:0], quo[SW-2:0], 1'b0};
    end
    return {diff[SW-1:0], quo[SW-2:0], 1'b1};
  endfunction

  assign step_x    = div_step(rem_x, quo_x, den);
  assign step_y    = div_step(rem_y, quo_y, den);
  assign load      = sums.start && !running;
  assign sums.busy = running;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      running <= 1'b0;
      done    <= 1'b0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (load) begin
        if (sums.count == '0) begin
          // nothing masked, answer right away
          done <= 1'b1;
        end else begin
          running <= 1'b1;
          bit_cnt <= CW'(SW);
        end
      end else if (running) begin
        bit_cnt <= bit_cnt - CW'(1);
        if (bit_cnt == CW'(1)) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (load) begin
      den   <= sums.count;
      quo_x <= sums.sum_x;
      quo_y <= sums.sum_y;
      rem_x <= '0;
      rem_y <= '0;
      if (sums.count == '0) begin
        empty <= 1'b1;
        x_com <= '0;
        y_com <= '0;
      end
    end else if (running) begin
      {rem_x, quo_x} <= step_x;
      {rem_y, quo_y} <= step_y;
      // last step, quotients fit the coordinate widths
      if (bit_cnt == CW'(1)) begin
        empty <= 1'b0;
        x_com <= step_x[HW-1:0];
        y_com <= step_y[VW-1:0];
      end
    end
  end

endmodule

//--- rtl/com_pkg.sv
package com_pkg;

  // coordinate sums and pixel count
  // 320*240 pixels at column 319 still fits in 28 bits
  localparam int SUM_W = 28;

  // threshold channel select codes
  localparam logic [1:0] CHAN_RED   = 2'd0;
  localparam logic [1:0] CHAN_GREEN = 2'd1;
  localparam logic [1:0] CHAN_BLUE  = 2'd2;

endpackage

//--- rtl/com_report.sv
`timescale 1ns/1ps

module com_report (
  input  logic                         clk_65mhz,
  input  logic                         sys_rst,
  input  logic [cam_pkg::HCOUNT_W-1:0] x_com,
  input  logic [cam_pkg::VCOUNT_W-1:0] y_com,
  input  logic                         empty,
  input  logic                         done,
  output logic                         com_req,
  input  logic                         com_ack,
  output logic [cam_pkg::HCOUNT_W-1:0] com_x,
  output logic [cam_pkg::VCOUNT_W-1:0] com_y,
  output logic                         com_empty
);

  // four-phase states
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_REQ     = 2'd1;
  localparam logic [1:0] ST_ACK_LOW = 2'd2;

  logic [1:0] state;
  logic       take;

  // results arriving mid-handshake are dropped
  assign take    = done && (state == ST_IDLE) && !com_ack;
  assign com_req = (state == ST_REQ);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:    if (take) state <= ST_REQ;
        ST_REQ:     if (com_ack) state <= ST_ACK_LOW;
        // req is down, wait for the far side to release ack
        ST_ACK_LOW: if (!com_ack) state <= ST_IDLE;
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // held for the whole request phase
  always_ff @(posedge clk_65mhz) begin
    if (take) begin
      com_x     <= x_com;
      com_y     <= y_com;
      com_empty <= empty;
    end
  end

endmodule

//--- rtl/com_sums_if.sv
`timescale 1ns/1ps

interface com_sums_if;

  // frame totals, held stable from start until the next start
  logic [com_pkg::SUM_W-1:0] sum_x;
  logic [com_pkg::SUM_W-1:0] sum_y;
  logic [com_pkg::SUM_W-1:0] count;
  logic                      start;
  // divider still working on the previous frame
  logic                      busy;

  modport source (output sum_x, sum_y, count, start, input  busy);
  modport sink   (input  sum_x, sum_y, count, start, output busy);

endinterface

//--- rtl/mask_accumulator.sv
`timescale 1ns/1ps

module mask_accumulator (
  input  logic       clk_65mhz,
  input  logic       sys_rst,
  input  logic [1:0] thresh_sel,
  input  logic [3:0] thresh_lo,
  input  logic [3:0] thresh_hi,
  pix_stream_if.sink pix,
  com_sums_if.source sums
);

  localparam int SW = com_pkg::SUM_W;

  logic [3:0]    chan;
  logic          chan_ok;
  logic          masked;
  logic          hand_over;
  logic [SW-1:0] acc_x;
  logic [SW-1:0] acc_y;
  logic [SW-1:0] acc_n;

  // top four bits of the chosen channel
  always_comb begin
    chan    = 4'd0;
    chan_ok = 1'b1;
    case (thresh_sel)
      com_pkg::CHAN_RED:   chan = pix.pixel.rgb.red[4:1];
      com_pkg::CHAN_GREEN: chan = pix.pixel.rgb.green[5:2];
      com_pkg::CHAN_BLUE:  chan = pix.pixel.rgb.blue[4:1];
      // unused code masks nothing
      default:             chan_ok = 1'b0;
    endcase
  end

  // inclusive window
  assign masked = pix.pix_valid && chan_ok && (chan >= thresh_lo) && (chan <= thresh_hi);

  // divider idle, so this frame's totals get used
  assign hand_over = pix.frame_end && !sums.busy;

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      acc_x      <= '0;
      acc_y      <= '0;
      acc_n      <= '0;
      sums.start <= 1'b0;
    end else begin
      sums.start <= hand_over;
      if (pix.frame_end) begin
        // next frame accumulates while the divider runs
        acc_x <= '0;
        acc_y <= '0;
        acc_n <= '0;
      end else if (masked) begin
        acc_x <= acc_x + SW'(pix.hcount);
        acc_y <= acc_y + SW'(pix.vcount);
        acc_n <= acc_n + SW'(1);
      end
    end
  end

  // totals held for the divider until the next hand-over
  always_ff @(posedge clk_65mhz) begin
    if (hand_over) begin
      sums.sum_x <= acc_x;
      sums.sum_y <= acc_y;
      sums.count <= acc_n;
    end
  end

endmodule

//--- rtl/pix_stream_if.sv
`timescale 1ns/1ps

interface pix_stream_if;

  // one strobe per complete pixel, no stall possible
  logic                          pix_valid;
  cam_pkg::pixel_u               pixel;
  logic [cam_pkg::HCOUNT_W-1:0]  hcount;
  logic [cam_pkg::VCOUNT_W-1:0]  vcount;
  // single pulse at vsync rise
  logic                          frame_end;

  modport source (output pix_valid, pixel, hcount, vcount, frame_end);
  modport sink   (input  pix_valid, pixel, hcount, vcount, frame_end);

endinterface

//--- src.f
rtl/cam_pkg.sv
rtl/com_pkg.sv
rtl/pix_stream_if.sv
rtl/com_sums_if.sv
rtl/cam_capture.sv
rtl/mask_accumulator.sv
rtl/com_divider.sv
rtl/com_report.sv
rtl/blob_tracker_top.sv
bench/tracker_asserts.sv
bench/tb_top.sv
